// ==== gamePkg.sv ====
package gamePkg;

    // game phases, in the order the controller walks them
    typedef enum logic [2:0] {
        Idle,
        StartScreen,
        StartGame,
        InGame,
        GameOver
    } gameState_e;

    // five holes on the board
    localparam int MoleCount = 5;

    // one bit per hole, bit 0 is hole 1
    typedef logic [MoleCount-1:0] moleMask_t;

    // 0 is no hit, 1..5 name a hole, 6 and 7 count as no hit
    typedef logic [2:0] hitCode_t;

    // round length in seconds
    localparam int RoundSeconds = 30;
    typedef logic [5:0] timeLeft_t;

    // score wraps at 256
    typedef logic [7:0] score_t;

    // board clock is 50 MHz
    localparam int DefaultTicksPerSecond = 50_000_000;

    // control lines decoded from the game state
    typedef struct packed {
        // high for the single StartGame cycle
        logic roundClear;
        // high for the whole of InGame
        logic playing;
    } gameControl_t;

endpackage

// ==== displayPkg.sv ====
package displayPkg;

    // seven segments, bit 0 is segment a, low lights the segment
    typedef logic [6:0] segments_t;

    // one hex digit to show
    typedef logic [3:0] hexDigit_t;

    // all six digits of the board, listed from the first field down
    typedef struct packed {
        segments_t timeLow;
        segments_t timeHigh;
        segments_t molesLow;
        segments_t molesHigh;
        segments_t scoreLow;
        segments_t scoreHigh;
    } displayBank_t;

endpackage

// ==== tickDivider.sv ====
module tickDivider import gamePkg::*; #(
    parameter int TicksPerPulse = DefaultTicksPerSecond
) (
    input  logic clock,
    input  logic reset,
    input  logic clear,
    output logic tick
);

    // wide enough to hold TicksPerPulse - 1
    typedef logic [$clog2(TicksPerPulse + 1)-1:0] count_t;

    count_t count;

    // count down from the period, reload at zero or on clear
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            count <= count_t'(TicksPerPulse - 1);
        end else if (clear || count == '0) begin
            count <= count_t'(TicksPerPulse - 1);
        end else begin
            count <= count - count_t'(1);
        end
    end

    // one-cycle pulse at the bottom of the count
    assign tick = (count == '0);

endmodule

// ==== gameController.sv ====
module gameController import gamePkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  logic         startGame,
    input  logic         timeUp,
    output gameState_e   gameState,
    output gameControl_t control
);

    gameState_e nextState;

    // state register
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            gameState <= Idle;
        end else begin
            gameState <= nextState;
        end
    end

    // next state
    always_comb begin
        nextState = gameState;
        case (gameState)
            Idle: begin
                nextState = StartScreen;
            end
            StartScreen: begin
                // wait here for the player
                if (startGame) begin
                    nextState = StartGame;
                end
            end
            StartGame: begin
                // one cycle to clear the round
                nextState = InGame;
            end
            InGame: begin
                if (timeUp) begin
                    nextState = GameOver;
                end
            end
            GameOver: begin
                // only reset leaves game over
                nextState = GameOver;
            end
            default: begin
                nextState = Idle;
            end
        endcase
    end

    // control lines straight from the current state
    always_comb begin
        control.roundClear = (gameState == StartGame);
        control.playing    = (gameState == InGame);
    end

endmodule

// ==== countdownTimer.sv ====
module countdownTimer import gamePkg::*; #(
    parameter int TicksPerSecond = DefaultTicksPerSecond
) (
    input  logic         clock,
    input  logic         reset,
    input  gameControl_t control,
    output logic         timeUp,
    output timeLeft_t    timeLeft
);

    logic secondTick;

    // one pulse per second, restarted with the round
    tickDivider #(
        .TicksPerPulse(TicksPerSecond)
    ) secondDivider_i (
        .clock(clock),
        .reset(reset),
        .clear(control.roundClear),
        .tick (secondTick)
    );

    // load on round start, count down while playing, stop at zero
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            timeLeft <= timeLeft_t'(RoundSeconds);
        end else if (control.roundClear) begin
            timeLeft <= timeLeft_t'(RoundSeconds);
        end else if (secondTick && control.playing && timeLeft != '0) begin
            timeLeft <= timeLeft - timeLeft_t'(1);
        end
    end

    // level, stays high until the next round load
    assign timeUp = (timeLeft == '0);

endmodule

// ==== moleGenerator.sv ====
module moleGenerator import gamePkg::*; #(
    parameter int TicksPerSecond = DefaultTicksPerSecond
) (
    input  logic         clock,
    input  logic         reset,
    input  gameControl_t control,
    input  moleMask_t    whack,
    output moleMask_t    molesShown
);

    logic       moleTick;
    logic [2:0] position;

    // one new mole per second
    tickDivider #(
        .TicksPerPulse(TicksPerSecond)
    ) moleDivider_i (
        .clock(clock),
        .reset(reset),
        .clear(control.roundClear),
        .tick (moleTick)
    );

    // free-running hole index 0..4
    // the player's timing against it makes the placement look random
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            position <= '0;
        end else if (position == 3'(MoleCount - 1)) begin
            position <= '0;
        end else begin
            position <= position + 3'd1;
        end
    end

    // a tick places a mole and wins over a whack in the same cycle
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            molesShown <= '0;
        end else if (control.roundClear) begin
            molesShown <= '0;
        end else if (moleTick && control.playing) begin
            molesShown <= moleMask_t'(1) << position;
        end else begin
            // knock out the mole that was hit
            molesShown <= molesShown & ~whack;
        end
    end

endmodule

// ==== hitScorer.sv ====
module hitScorer import gamePkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  gameControl_t control,
    input  hitCode_t     hitCode,
    input  moleMask_t    molesShown,
    output moleMask_t    whack,
    output score_t       score,
    output logic         hitFlag,
    output logic         missFlag
);

    moleMask_t hitMask;
    logic      isHit;
    logic      isMiss;

    // hole number to mask, codes past the last hole mean nothing
    always_comb begin
        hitMask = '0;
        if (hitCode != '0 && hitCode <= hitCode_t'(MoleCount)) begin
            hitMask = moleMask_t'(1) << (hitCode - hitCode_t'(1));
        end
    end

    // judged only while the round runs
    assign whack  = control.playing ? (hitMask & molesShown) : '0;
    assign isHit  = (whack != '0);
    assign isMiss = control.playing && (hitMask != '0) && !isHit;

    // score counts hits, cleared at round start
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            score <= '0;
        end else if (control.roundClear) begin
            score <= '0;
        end else if (isHit) begin
            score <= score + score_t'(1);
        end
    end

    // flags show last cycle's judgement
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            hitFlag  <= 1'b0;
            missFlag <= 1'b0;
        end else begin
            hitFlag  <= isHit;
            missFlag <= isMiss;
        end
    end

endmodule

// ==== segmentDecoder.sv ====
module segmentDecoder import displayPkg::*; (
    input  hexDigit_t digit,
    output segments_t segments
);

    // active low, bit order gfedcba
    always_comb begin
        case (digit)
            4'h0:    segments = 7'b1000000;
            4'h1:    segments = 7'b1111001;
            4'h2:    segments = 7'b0100100;
            4'h3:    segments = 7'b0110000;
            4'h4:    segments = 7'b0011001;
            4'h5:    segments = 7'b0010010;
            4'h6:    segments = 7'b0000010;
            4'h7:    segments = 7'b1111000;
            4'h8:    segments = 7'b0000000;
            4'h9:    segments = 7'b0010000;
            // letters, b and d in lower case
            4'hA:    segments = 7'b0001000;
            4'hB:    segments = 7'b0000011;
            4'hC:    segments = 7'b1000110;
            4'hD:    segments = 7'b0100001;
            4'hE:    segments = 7'b0000110;
            4'hF:    segments = 7'b0001110;
            default: segments = 7'b1111111;
        endcase
    end

endmodule

// ==== whackAMole.sv ====
module whackAMole import gamePkg::*, displayPkg::*; #(
    parameter int TicksPerSecond = DefaultTicksPerSecond
) (
    input  logic         clock,
    input  logic         reset,
    input  logic         startGame,
    input  hitCode_t     hitCode,
    output gameState_e   gameState,
    output moleMask_t    molesShown,
    output timeLeft_t    timeLeft,
    output score_t       score,
    output logic         hitFlag,
    output logic         missFlag,
    output displayBank_t display
);

    gameControl_t control;
    logic         timeUp;
    moleMask_t    whack;

    gameController gameController_i (
        .clock    (clock),
        .reset    (reset),
        .startGame(startGame),
        .timeUp   (timeUp),
        .gameState(gameState),
        .control  (control)
    );

    // round clock
    countdownTimer #(
        .TicksPerSecond(TicksPerSecond)
    ) countdownTimer_i (
        .clock   (clock),
        .reset   (reset),
        .control (control),
        .timeUp  (timeUp),
        .timeLeft(timeLeft)
    );

    // mole placement, takes the whack back from the scorer
    moleGenerator #(
        .TicksPerSecond(TicksPerSecond)
    ) moleGenerator_i (
        .clock     (clock),
        .reset     (reset),
        .control   (control),
        .whack     (whack),
        .molesShown(molesShown)
    );

    hitScorer hitScorer_i (
        .clock     (clock),
        .reset     (reset),
        .control   (control),
        .hitCode   (hitCode),
        .molesShown(molesShown),
        .whack     (whack),
        .score     (score),
        .hitFlag   (hitFlag),
        .missFlag  (missFlag)
    );

    // high nibbles padded with zero
    segmentDecoder timeLow_i (
        .digit   (timeLeft[3:0]),
        .segments(display.timeLow)
    );
    segmentDecoder timeHigh_i (
        .digit   ({2'b00, timeLeft[5:4]}),
        .segments(display.timeHigh)
    );
    segmentDecoder molesLow_i (
        .digit   (molesShown[3:0]),
        .segments(display.molesLow)
    );
    segmentDecoder molesHigh_i (
        .digit   ({3'b000, molesShown[4]}),
        .segments(display.molesHigh)
    );
    segmentDecoder scoreLow_i (
        .digit   (score[3:0]),
        .segments(display.scoreLow)
    );
    segmentDecoder scoreHigh_i (
        .digit   (score[7:4]),
        .segments(display.scoreHigh)
    );

endmodule

// ==== gameMonitor.sv ====
module gameMonitor import gamePkg::*, displayPkg::*; #(
    parameter int TicksPerSecond = 8
) (
    input  logic         clock,
    input  logic         reset,
    input  logic         startGame,
    input  hitCode_t     hitCode,
    input  gameState_e   gameState,
    input  moleMask_t    molesShown,
    input  timeLeft_t    timeLeft,
    input  score_t       score,
    input  logic         hitFlag,
    input  logic         missFlag,
    input  displayBank_t display,
    output int           checkCount,
    output int           errorCount
);

    // active-low hex patterns, bit 0 is segment a
    localparam segments_t HexTable [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
    };

    int checks = 0;
    int errors = 0;

    // model of the game, valid for the cycle before each edge
    gameState_e   mState;
    moleMask_t    mMoles;
    timeLeft_t    mTime;
    score_t       mScore;
    logic         mHit;
    logic         mMiss;
    // second divider count and hole position
    int           mCount;
    int           mPos;
    displayBank_t expDisplay;

    assign checkCount = checks;
    assign errorCount = errors;

    task automatic checkValue(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[ERROR] %s at %0t expected %0h actual %0h", name, $time, expected, actual);
        end
    endtask

    task automatic checkRule(input logic ok, input string what);
        checks++;
        if (!ok) begin
            errors++;
            $display("%s at %0t", what, $time);
        end
    endtask

    task automatic compareOutputs();
        checkValue("gameState", 64'(mState), 64'(gameState));
        checkValue("molesShown", 64'(mMoles), 64'(molesShown));
        checkValue("timeLeft", 64'(mTime), 64'(timeLeft));
        checkValue("score", 64'(mScore), 64'(score));
        checkValue("hitFlag", 64'(mHit), 64'(hitFlag));
        checkValue("missFlag", 64'(mMiss), 64'(missFlag));
        checkRule($countones(molesShown) <= 1, "more than one mole is shown at once");
        checkRule(!(hitFlag && missFlag), "hit and miss flags are high together");
        // digits follow the model's field nibbles, upper ones zero padded
        expDisplay.timeLow   = HexTable[mTime[3:0]];
        expDisplay.timeHigh  = HexTable[{2'b00, mTime[5:4]}];
        expDisplay.molesLow  = HexTable[mMoles[3:0]];
        expDisplay.molesHigh = HexTable[{3'b000, mMoles[4]}];
        expDisplay.scoreLow  = HexTable[mScore[3:0]];
        expDisplay.scoreHigh = HexTable[mScore[7:4]];
        checkValue("display", 64'(expDisplay), 64'(display));
    endtask

    task automatic advanceModel();
        gameState_e next;
        moleMask_t  named;
        moleMask_t  hitHole;
        logic       tick;
        next = mState;
        case (mState)
            Idle:        next = StartScreen;
            StartScreen: next = startGame ? StartGame : StartScreen;
            StartGame:   next = InGame;
            InGame:      next = (mTime == '0) ? GameOver : InGame;
            default:     next = mState;
        endcase
        // codes 1..5 name a hole, anything else is no hit
        named = '0;
        if (hitCode >= 3'd1 && hitCode <= 3'd5) begin
            named = moleMask_t'(1) << (hitCode - 3'd1);
        end
        hitHole = (mState == InGame) ? (named & mMoles) : '0;
        tick    = (mCount == 0);
        mHit    = (hitHole != '0);
        mMiss   = (mState == InGame) && (named != '0) && (hitHole == '0);
        if (mState == StartGame) begin
            mMoles = '0;
            mTime  = timeLeft_t'(RoundSeconds);
            mScore = '0;
            mCount = TicksPerSecond - 1;
        end else begin
            // a new mole wins over a knock-out
            if (mState == InGame && tick) begin
                mMoles = moleMask_t'(1) << mPos;
            end else begin
                mMoles = mMoles & ~hitHole;
            end
            if (mState == InGame && tick && mTime != '0) begin
                mTime = mTime - timeLeft_t'(1);
            end
            if (hitHole != '0) begin
                mScore = mScore + score_t'(1);
            end
            mCount = tick ? TicksPerSecond - 1 : mCount - 1;
        end
        mPos   = (mPos == MoleCount - 1) ? 0 : mPos + 1;
        mState = next;
    endtask

    // inputs and outputs are read before the edge updates them
    always @(posedge clock) begin
        if (reset) begin
            mState = Idle;
            mMoles = '0;
            mTime  = timeLeft_t'(RoundSeconds);
            mScore = '0;
            mHit   = 1'b0;
            mMiss  = 1'b0;
            mCount = TicksPerSecond - 1;
            mPos   = 0;
        end else begin
            compareOutputs();
            advanceModel();
        end
    end

endmodule

// ==== whackAMoleTb.sv ====
module whackAMoleTb import gamePkg::*, displayPkg::*; ();

    localparam int TicksPerSecond = 8;
    localparam int Rounds         = 2;
    localparam int ClockPeriod    = 20;
    localparam int Seed           = 32'h088909c3;
    // both rounds plus slack for reset and start delays
    localparam int WatchdogCycles = Rounds * RoundSeconds * TicksPerSecond + 200;

    logic         clock = 1'b0;
    logic         reset;
    logic         startGame;
    hitCode_t     hitCode;
    gameState_e   gameState;
    moleMask_t    molesShown;
    timeLeft_t    timeLeft;
    score_t       score;
    logic         hitFlag;
    logic         missFlag;
    displayBank_t display;
    int           checkCount;
    int           errorCount;

    always #(ClockPeriod / 2) clock = ~clock;

    whackAMole #(
        .TicksPerSecond(TicksPerSecond)
    ) whackAMole_i (
        .clock     (clock),
        .reset     (reset),
        .startGame (startGame),
        .hitCode   (hitCode),
        .gameState (gameState),
        .molesShown(molesShown),
        .timeLeft  (timeLeft),
        .score     (score),
        .hitFlag   (hitFlag),
        .missFlag  (missFlag),
        .display   (display)
    );

    gameMonitor #(
        .TicksPerSecond(TicksPerSecond)
    ) gameMonitor_i (
        .clock     (clock),
        .reset     (reset),
        .startGame (startGame),
        .hitCode   (hitCode),
        .gameState (gameState),
        .molesShown(molesShown),
        .timeLeft  (timeLeft),
        .score     (score),
        .hitFlag   (hitFlag),
        .missFlag  (missFlag),
        .display   (display),
        .checkCount(checkCount),
        .errorCount(errorCount)
    );

    task automatic applyReset();
        @(posedge clock);
        reset <= 1'b1;
        repeat (3) @(posedge clock);
        reset <= 1'b0;
    endtask

    // random code 0..7 held for one to four cycles
    task automatic holdRandomHit();
        int hold;
        hold = $urandom_range(4, 1);
        hitCode <= hitCode_t'($urandom_range(7, 0));
        repeat (hold) @(posedge clock);
    endtask

    task automatic playRound();
        int delay;
        applyReset();
        // codes before the start must not score
        delay = $urandom_range(6, 1);
        repeat (delay) holdRandomHit();
        startGame <= 1'b1;
        @(posedge clock);
        startGame <= 1'b0;
        while (gameState != GameOver) begin
            holdRandomHit();
        end
        // game over has to hold until reset
        repeat (4) holdRandomHit();
    endtask

    initial begin
        reset     = 1'b1;
        startGame = 1'b0;
        hitCode   = '0;
        void'($urandom(Seed));
        repeat (Rounds) playRound();
        @(negedge clock);
        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WatchdogCycles * ClockPeriod);
        $display("timeout, the rounds did not reach game over in time");
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== filelist.f ====
gamePkg.sv
displayPkg.sv
tickDivider.sv
gameController.sv
countdownTimer.sv
moleGenerator.sv
hitScorer.sv
segmentDecoder.sv
whackAMole.sv
gameMonitor.sv
whackAMoleTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the whack-a-mole testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module whackAMoleTb -o simv
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SIMULATION FAILED" sim.log; then
    exit 1
fi
exit 0
